// File: Bender.yml
package:
  name: rv32i_cpu

sources:
  - files:
      - source/rv_isa_pkg.sv
      - source/cpu_pipe_pkg.sv
      - source/gpr_if.sv
      - source/stage_reg.sv
      - source/ifu.sv
      - source/gpr.sv
      - source/idu.sv
      - source/exu.sv
      - source/lsu.sv
      - source/cpu.sv
  - target: simulation
    files:
      - bench/cpu_tb.sv

// File: all.f
source/rv_isa_pkg.sv
source/cpu_pipe_pkg.sv
source/gpr_if.sv
source/stage_reg.sv
source/ifu.sv
source/gpr.sv
source/idu.sv
source/exu.sv
source/lsu.sv
source/cpu.sv
bench/cpu_tb.sv

// File: bench/cpu_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_tb;
    import rv_isa_pkg::*;

    localparam int unsigned SEED      = 32'hb2ddd590;
    localparam int          ROM_WORDS = 64;
    localparam int          RAM_WORDS = 64;
    localparam inst_t       EBREAK    = 32'h0010_0073;
    localparam logic [2:0]  F3_WORD   = 3'b010;
    localparam int          RES_BASE  = 64;
    localparam int          SUM_N     = 12;

    // Instructions executed by each test program
    localparam int LEN_TIMING = 5;
    localparam int LEN_ALU    = 41;
    localparam int LEN_MEM    = 10;
    localparam int LEN_BRANCH = 3 * SUM_N + 6;
    localparam int LEN_JUMP   = 5;
    localparam int CYCLE_LIMIT = 4 * (LEN_TIMING + LEN_ALU + LEN_MEM + LEN_BRANCH + LEN_JUMP)
                                 + 16 * 5 + 100;

    logic  i_sys_clk;
    logic  i_reset;
    addr_t rom_addr;
    inst_t rom_data;
    addr_t ram_addr;
    data_t ram_rdata;
    logic  ram_we;
    data_t ram_wdata;
    logic  end_flag;
    data_t end_data;

    inst_t rom [ROM_WORDS];
    data_t ram [RAM_WORDS];
    inst_t prog [$];
    int    errors;
    int    cycles = 0;

    cpu UUT (
        .i_sys_clk (i_sys_clk), .i_reset(i_reset),
        .o_rom_addr(rom_addr),  .i_rom_data(rom_data),
        .o_ram_addr(ram_addr),  .i_ram_data(ram_rdata),
        .o_ram_we  (ram_we),    .o_ram_wdata(ram_wdata),
        .o_end_flag(end_flag),  .o_end_data(end_data)
    );

    // Both memories answer in the same cycle
    assign rom_data  = rom[rom_addr[7:2]];
    assign ram_rdata = ram[ram_addr[7:2]];

    always @(posedge i_sys_clk) begin
        if (ram_we) begin
            ram[ram_addr[7:2]] <= ram_wdata;
        end
    end

    initial begin
        i_sys_clk = 1'b0;
        forever #4 i_sys_clk = ~i_sys_clk;
    end

    always @(posedge i_sys_clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles without finishing, %0d errors",
                     CYCLE_LIMIT, errors);
            $display("sim failed");
            $finish;
        end
    end

    function automatic inst_t enc_r(input logic [2:0] f3, input logic [6:0] f7,
                                    input reg_id_t rd, input reg_id_t rs1, input reg_id_t rs2);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic inst_t enc_i(input logic [6:0] op, input logic [2:0] f3,
                                    input reg_id_t rd, input reg_id_t rs1, input int imm);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    // sw rs2, imm(rs1)
    function automatic inst_t enc_s(input reg_id_t rs2, input reg_id_t rs1, input int imm);
        return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OP_STORE};
    endfunction

    function automatic inst_t enc_b(input logic [2:0] f3, input reg_id_t rs1,
                                    input reg_id_t rs2, input int off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic inst_t enc_u(input logic [6:0] op, input reg_id_t rd, input int imm);
        return {imm[19:0], rd, op};
    endfunction

    function automatic inst_t enc_j(input reg_id_t rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    // Operation kinds in order add sub sll slt sltu xor srl sra or and
    function automatic logic [2:0] kind_f3(input int k);
        case (k)
            0, 1:    return 3'b000;
            2:       return 3'b001;
            3:       return 3'b010;
            4:       return 3'b011;
            5:       return 3'b100;
            6, 7:    return 3'b101;
            8:       return 3'b110;
            default: return 3'b111;
        endcase
    endfunction

    function automatic data_t alu_rule(input int k, input data_t a, input data_t b);
        case (k)
            0:       return a + b;
            1:       return a - b;
            2:       return a << b[4:0];
            3:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            4:       return (a < b) ? 32'd1 : 32'd0;
            5:       return a ^ b;
            6:       return a >> b[4:0];
            7:       return data_t'($signed(a) >>> b[4:0]);
            8:       return a | b;
            default: return a & b;
        endcase
    endfunction

    // Distinct per byte address so a stray access shows up
    function automatic data_t fill_word(input int i);
        return (data_t'(i * 4) * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    endfunction

    task automatic check_data(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge i_sys_clk);
        #1;
    endtask

    task automatic load_program();
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = (i < prog.size()) ? prog[i] : EBREAK;
        end
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram[i] <= fill_word(i);
        end
    endtask

    task automatic apply_reset();
        next_cycle();
        i_reset = 1'b1;
        repeat (16) next_cycle();
        i_reset = 1'b0;
    endtask

    task automatic wait_end(input int instrs, input string name);
        int limit;
        limit = instrs * 4 + 8;
        for (int n = 0; n < limit && !end_flag; n++) begin
            next_cycle();
        end
        if (!end_flag) begin
            errors++;
            $display("Test %s did not reach EBREAK within %0d cycles", name, limit);
        end
    endtask

    task automatic check_halt();
        addr_t held;
        held = rom_addr;
        repeat (12) begin
            next_cycle();
            check_bit(end_flag, 1'b1, "end flag after EBREAK");
            check_addr(rom_addr, held, "fetch address after EBREAK");
            check_bit(ram_we, 1'b0, "RAM write enable after EBREAK");
        end
    endtask

    task automatic test_reset_timing();
        addr_t pc;
        prog.delete();
        prog.push_back(enc_i(OP_IMM, 3'b000, 10, 0, 5));
        prog.push_back(enc_i(OP_IMM, 3'b000, 10, 10, 7));
        prog.push_back(enc_i(OP_IMM, 3'b000, 10, 10, -2));
        prog.push_back(enc_i(OP_IMM, 3'b000, 11, 10, 1));
        prog.push_back(EBREAK);
        // Store that must never run once EBREAK retires
        prog.push_back(enc_s(10, 0, 0));
        load_program();
        apply_reset();
        pc = '0;
        check_bit(ram_we, 1'b0, "RAM write enable after reset");
        check_bit(end_flag, 1'b0, "end flag after reset");
        check_addr(rom_addr, pc, "fetch address after reset");
        // One cycle to issue the first fetch and four per instruction
        for (int k = 0; k < 4; k++) begin
            repeat ((k == 0) ? 4 : 3) next_cycle();
            check_addr(rom_addr, pc, "fetch address held");
            next_cycle();
            pc += 4;
            check_addr(rom_addr, pc, "fetch address advanced");
        end
        wait_end(LEN_TIMING, "reset and timing");
        check_data(end_data, 32'd10, "x10 after straight-line code");
        check_halt();
    endtask

    task automatic test_alu();
        data_t a;
        data_t b;
        data_t opnd;
        int    imm;
        int    slot;
        data_t exp_words [$];
        a = $urandom();
        b = $urandom();
        slot = 0;
        prog.delete();
        prog.push_back(enc_i(OP_LOAD, F3_WORD, 1, 0, 0));
        prog.push_back(enc_i(OP_LOAD, F3_WORD, 2, 0, 4));
        for (int k = 0; k < 10; k++) begin
            prog.push_back(enc_r(kind_f3(k), (k == 1 || k == 7) ? 7'h20 : 7'h00, 3, 1, 2));
            prog.push_back(enc_s(3, 0, RES_BASE + 4 * slot));
            exp_words.push_back(alu_rule(k, a, b));
            slot++;
        end
        for (int k = 0; k < 10; k++) begin
            if (k == 1) continue;
            if (k == 2 || k == 6 || k == 7) begin
                imm = int'($urandom() & 32'h1f);
                opnd = data_t'(imm);
                if (k == 7) imm += 32'h400;
            end else begin
                imm = int'($urandom() & 32'hfff);
                opnd = {{20{imm[11]}}, imm[11:0]};
            end
            prog.push_back(enc_i(OP_IMM, kind_f3(k), 3, 1, imm));
            prog.push_back(enc_s(3, 0, RES_BASE + 4 * slot));
            exp_words.push_back(alu_rule(k, a, opnd));
            slot++;
        end
        prog.push_back(EBREAK);
        load_program();
        ram[0] <= a;
        ram[1] <= b;
        apply_reset();
        wait_end(LEN_ALU, "ALU");
        for (int s = 0; s < slot; s++) begin
            check_data(ram[RES_BASE / 4 + s], exp_words[s], $sformatf("ALU result slot %0d", s));
        end
    endtask

    task automatic test_load_store();
        data_t word;
        int    up1;
        int    up2;
        word = $urandom();
        up1 = int'($urandom() & 32'hfffff);
        up2 = int'($urandom() & 32'hfffff);
        prog.delete();
        prog.push_back(enc_i(OP_LOAD, F3_WORD, 7, 0, 8));
        prog.push_back(enc_s(7, 0, 'h80));
        prog.push_back(enc_i(OP_IMM, 3'b000, 0, 0, 'h123));
        prog.push_back(enc_s(0, 0, 'h84));
        prog.push_back(enc_u(OP_LUI, 8, up1));
        prog.push_back(enc_s(8, 0, 'h88));
        prog.push_back(enc_u(OP_AUIPC, 9, up2));
        prog.push_back(enc_s(9, 0, 'h8c));
        prog.push_back(enc_i(OP_LOAD, F3_WORD, 10, 0, 'h80));
        prog.push_back(EBREAK);
        load_program();
        ram[2] <= word;
        apply_reset();
        wait_end(LEN_MEM, "load and store");
        check_data(end_data, word, "x10 loaded back");
        check_data(ram[32], word, "stored word");
        check_data(ram[33], 32'd0, "x0 after write attempt");
        check_data(ram[34], data_t'(up1) << 12, "LUI result");
        // AUIPC sits at word 6
        check_data(ram[35], 32'd24 + (data_t'(up2) << 12), "AUIPC result");
    endtask

    task automatic test_branches();
        prog.delete();
        prog.push_back(enc_i(OP_IMM, 3'b000, 10, 0, 0));
        prog.push_back(enc_i(OP_IMM, 3'b000, 11, 0, 1));
        prog.push_back(enc_i(OP_IMM, 3'b000, 12, 0, SUM_N + 1));
        prog.push_back(enc_r(3'b000, 7'h00, 10, 10, 11));
        prog.push_back(enc_i(OP_IMM, 3'b000, 11, 11, 1));
        prog.push_back(enc_b(3'b001, 11, 12, -8));
        prog.push_back(enc_b(3'b100, 0, 11, 8));
        prog.push_back(enc_i(OP_IMM, 3'b000, 10, 0, 0));
        prog.push_back(enc_b(3'b000, 10, 0, 8));
        prog.push_back(EBREAK);
        prog.push_back(enc_i(OP_IMM, 3'b000, 10, 0, 0));
        prog.push_back(EBREAK);
        load_program();
        apply_reset();
        wait_end(LEN_BRANCH, "branches");
        check_data(end_data, data_t'(SUM_N * (SUM_N + 1) / 2), "loop sum in x10");
        check_addr(rom_addr, 32'd36, "EBREAK address after branches");
    endtask

    task automatic test_jumps();
        prog.delete();
        prog.push_back(enc_j(1, 12));
        prog.push_back(enc_i(OP_IMM, 3'b000, 10, 0, 1));
        prog.push_back(EBREAK);
        // Target 4 + 21 has bit 0 set and lands on word 6
        prog.push_back(enc_i(OP_JALR, 3'b000, 10, 1, 21));
        prog.push_back(enc_i(OP_IMM, 3'b000, 10, 0, 2));
        prog.push_back(EBREAK);
        prog.push_back(enc_i(OP_IMM, 3'b001, 11, 10, 8));
        prog.push_back(enc_r(3'b000, 7'h00, 10, 11, 1));
        prog.push_back(EBREAK);
        load_program();
        apply_reset();
        wait_end(LEN_JUMP, "jumps");
        check_data(end_data, (32'd16 << 8) + 32'd4, "link values in x10");
        check_addr(rom_addr, 32'd32, "EBREAK address after jumps");
    endtask

    initial begin
        errors = 0;
        i_reset = 1'b1;
        void'($urandom(SEED));
        prog.delete();
        load_program();
        test_reset_timing();
        test_alu();
        test_load_store();
        test_branches();
        test_jumps();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/cpu.sv
`timescale 1ns/100ps
`default_nettype none

module cpu (
    input  logic              i_sys_clk,
    input  logic              i_reset,
    output rv_isa_pkg::addr_t o_rom_addr,
    input  rv_isa_pkg::inst_t i_rom_data,
    output rv_isa_pkg::addr_t o_ram_addr,
    input  rv_isa_pkg::data_t i_ram_data,
    output logic              o_ram_we,
    output rv_isa_pkg::data_t o_ram_wdata,
    output logic              o_end_flag,
    output rv_isa_pkg::data_t o_end_data
);
    import rv_isa_pkg::*;
    import cpu_pipe_pkg::*;

    // Fetch to decode
    logic       w_ifu_valid;
    logic       w_ifu_ready;
    addr_t      w_ifu_pc;
    logic       w_i2i_valid;
    logic       w_i2i_ready;
    addr_t      w_i2i_pc;

    // Decode to execute
    logic       w_idu_valid;
    logic       w_idu_ready;
    dec_to_ex_t w_idu_data;
    logic       w_i2e_valid;
    logic       w_i2e_ready;
    dec_to_ex_t w_i2e_data;

    // Execute to memory
    logic       w_exu_valid;
    logic       w_exu_ready;
    ex_to_mem_t w_exu_data;
    logic       w_e2l_valid;
    logic       w_e2l_ready;
    ex_to_mem_t w_e2l_data;

    logic       w_retire;
    addr_t      w_next_pc;

    gpr_if u_gpr_if ();

    assign o_rom_addr = w_ifu_pc;

    ifu u_ifu (
        .i_sys_clk(i_sys_clk),   .i_reset(i_reset),
        .i_retire (w_retire),    .i_next_pc(w_next_pc),
        .i_halt   (o_end_flag),  .o_valid(w_ifu_valid),
        .i_ready  (w_ifu_ready), .o_pc(w_ifu_pc)
    );

    stage_reg #(.T(addr_t)) u_if_id (
        .i_sys_clk(i_sys_clk),   .i_reset(i_reset),
        .i_valid  (w_ifu_valid), .o_ready(w_ifu_ready), .i_data(w_ifu_pc),
        .o_valid  (w_i2i_valid), .i_ready(w_i2i_ready), .o_data(w_i2i_pc)
    );

    idu u_idu (
        .i_valid (w_i2i_valid), .o_ready(w_i2i_ready),
        .i_pc    (w_i2i_pc),    .i_inst(i_rom_data),
        .gpr_port(u_gpr_if.reader),
        .o_valid (w_idu_valid), .i_ready(w_idu_ready), .o_data(w_idu_data)
    );

    gpr u_gpr (
        .i_sys_clk(i_sys_clk), .i_reset(i_reset),
        .gpr_port (u_gpr_if.regfile), .o_end_data(o_end_data)
    );

    stage_reg #(.T(dec_to_ex_t)) u_id_ex (
        .i_sys_clk(i_sys_clk),   .i_reset(i_reset),
        .i_valid  (w_idu_valid), .o_ready(w_idu_ready), .i_data(w_idu_data),
        .o_valid  (w_i2e_valid), .i_ready(w_i2e_ready), .o_data(w_i2e_data)
    );

    exu u_exu (
        .i_valid(w_i2e_valid), .o_ready(w_i2e_ready), .i_data(w_i2e_data),
        .o_valid(w_exu_valid), .i_ready(w_exu_ready), .o_data(w_exu_data)
    );

    stage_reg #(.T(ex_to_mem_t)) u_ex_mem (
        .i_sys_clk(i_sys_clk),   .i_reset(i_reset),
        .i_valid  (w_exu_valid), .o_ready(w_exu_ready), .i_data(w_exu_data),
        .o_valid  (w_e2l_valid), .i_ready(w_e2l_ready), .o_data(w_e2l_data)
    );

    lsu u_lsu (
        .i_sys_clk  (i_sys_clk),   .i_reset(i_reset),
        .i_valid    (w_e2l_valid), .o_ready(w_e2l_ready), .i_data(w_e2l_data),
        .o_ram_addr (o_ram_addr),  .i_ram_data(i_ram_data),
        .o_ram_we   (o_ram_we),    .o_ram_wdata(o_ram_wdata),
        .gpr_port   (u_gpr_if.writer),
        .o_retire   (w_retire),    .o_next_pc(w_next_pc),
        .o_end_flag (o_end_flag)
    );

endmodule

`default_nettype wire

// File: source/cpu_pipe_pkg.sv
`default_nettype none

package cpu_pipe_pkg;

    typedef enum logic [3 : 0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic { OPA_REG, OPA_PC } op_a_sel_e;
    typedef enum logic { OPB_REG, OPB_IMM } op_b_sel_e;

    typedef enum logic [3 : 0] {
        BR_NONE, BR_JAL, BR_JALR, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } br_type_e;

    typedef enum logic [1 : 0] { WB_ALU, WB_MEM, WB_PC4 } wb_src_e;

    typedef struct packed {
        alu_op_e   alu_op;
        op_a_sel_e op_a_sel;
        op_b_sel_e op_b_sel;
        br_type_e  br_type;
        wb_src_e   wb_src;
        logic      reg_we;
        logic      mem_rd;
        logic      mem_wr;
        logic      ebreak;
    } ctrl_t;

    typedef struct packed {
        rv_isa_pkg::addr_t   pc;
        ctrl_t               ctrl;
        rv_isa_pkg::data_t   rs1_val;
        rv_isa_pkg::data_t   rs2_val;
        rv_isa_pkg::data_t   imm;
        rv_isa_pkg::reg_id_t rd;
    } dec_to_ex_t;

    typedef struct packed {
        rv_isa_pkg::addr_t   pc4;
        rv_isa_pkg::addr_t   next_pc;
        rv_isa_pkg::data_t   alu_res;
        rv_isa_pkg::data_t   store_data;
        rv_isa_pkg::reg_id_t rd;
        ctrl_t               ctrl;
    } ex_to_mem_t;

endpackage

`default_nettype wire

// File: source/exu.sv
`timescale 1ns/100ps
`default_nettype none

module exu (
    input  logic                     i_valid,
    output logic                     o_ready,
    input  cpu_pipe_pkg::dec_to_ex_t i_data,
    output logic                     o_valid,
    input  logic                     i_ready,
    output cpu_pipe_pkg::ex_to_mem_t o_data
);
    import rv_isa_pkg::*;
    import cpu_pipe_pkg::*;

    data_t        w_op_a;
    data_t        w_op_b;
    data_t        w_alu_res;
    logic [4 : 0] w_shamt;
    logic         w_taken;
    addr_t        w_pc4;
    addr_t        w_target;
    addr_t        w_next_pc;

    assign w_op_a  = (i_data.ctrl.op_a_sel == OPA_PC) ? i_data.pc : i_data.rs1_val;
    assign w_op_b  = (i_data.ctrl.op_b_sel == OPB_IMM) ? i_data.imm : i_data.rs2_val;
    assign w_shamt = w_op_b[4:0];

    always_comb begin
        case (i_data.ctrl.alu_op)
            ALU_SUB:  w_alu_res = w_op_a - w_op_b;
            ALU_SLL:  w_alu_res = w_op_a << w_shamt;
            ALU_SLT:  w_alu_res = data_t'($signed(w_op_a) < $signed(w_op_b));
            ALU_SLTU: w_alu_res = data_t'(w_op_a < w_op_b);
            ALU_XOR:  w_alu_res = w_op_a ^ w_op_b;
            ALU_SRL:  w_alu_res = w_op_a >> w_shamt;
            ALU_SRA:  w_alu_res = $signed(w_op_a) >>> w_shamt;
            ALU_OR:   w_alu_res = w_op_a | w_op_b;
            ALU_AND:  w_alu_res = w_op_a & w_op_b;
            default:  w_alu_res = w_op_a + w_op_b;
        endcase
    end

    // Branches compare the two register values
    always_comb begin
        case (i_data.ctrl.br_type)
            BR_EQ:   w_taken = i_data.rs1_val == i_data.rs2_val;
            BR_NE:   w_taken = i_data.rs1_val != i_data.rs2_val;
            BR_LT:   w_taken = $signed(i_data.rs1_val) < $signed(i_data.rs2_val);
            BR_GE:   w_taken = $signed(i_data.rs1_val) >= $signed(i_data.rs2_val);
            BR_LTU:  w_taken = i_data.rs1_val < i_data.rs2_val;
            BR_GEU:  w_taken = i_data.rs1_val >= i_data.rs2_val;
            default: w_taken = 1'b0;
        endcase
    end

    assign w_pc4    = i_data.pc + 32'd4;
    assign w_target = i_data.pc + i_data.imm;

    always_comb begin
        case (i_data.ctrl.br_type)
            BR_NONE: w_next_pc = w_pc4;
            BR_JAL:  w_next_pc = w_target;
            BR_JALR: w_next_pc = (i_data.rs1_val + i_data.imm) & ~32'd1;
            default: w_next_pc = w_taken ? w_target : w_pc4;
        endcase
    end

    assign o_data.pc4        = w_pc4;
    assign o_data.next_pc    = w_next_pc;
    assign o_data.alu_res    = w_alu_res;
    assign o_data.store_data = i_data.rs2_val;
    assign o_data.rd         = i_data.rd;
    assign o_data.ctrl       = i_data.ctrl;

    assign o_valid = i_valid;
    assign o_ready = i_ready;

endmodule

`default_nettype wire

// File: source/gpr.sv
`timescale 1ns/100ps
`default_nettype none

module gpr (
    input  logic              i_sys_clk,
    input  logic              i_reset,
    gpr_if.regfile            gpr_port,
    output rv_isa_pkg::data_t o_end_data
);
    import rv_isa_pkg::*;

    data_t r_regs [32];

    always_ff @(posedge i_sys_clk) begin
        if (i_reset) begin
            for (int i = 0; i < 32; i++) begin
                r_regs[i] <= '0;
            end
        end else if (gpr_port.wr_en && gpr_port.wr_id != '0) begin
            r_regs[gpr_port.wr_id] <= gpr_port.wr_data;
        end
    end

    // x0 always reads zero
    assign gpr_port.rs1_data = (gpr_port.rs1_id == '0) ? '0 : r_regs[gpr_port.rs1_id];
    assign gpr_port.rs2_data = (gpr_port.rs2_id == '0) ? '0 : r_regs[gpr_port.rs2_id];
    assign o_end_data        = r_regs[END_REG];

    a_wr_id_known: assert property (@(posedge i_sys_clk) disable iff (i_reset)
        gpr_port.wr_en |-> !$isunknown(gpr_port.wr_id));

endmodule

`default_nettype wire

// File: source/gpr_if.sv
`timescale 1ns/100ps
`default_nettype none

interface gpr_if;
    import rv_isa_pkg::*;

    reg_id_t rs1_id;
    reg_id_t rs2_id;
    data_t   rs1_data;
    data_t   rs2_data;
    logic    wr_en;
    reg_id_t wr_id;
    data_t   wr_data;

    modport reader  (output rs1_id, rs2_id, input rs1_data, rs2_data);
    modport writer  (output wr_en, wr_id, wr_data);
    modport regfile (input rs1_id, rs2_id, wr_en, wr_id, wr_data,
                     output rs1_data, rs2_data);

endinterface

`default_nettype wire

// File: source/idu.sv
`timescale 1ns/100ps
`default_nettype none

module idu (
    input  logic                     i_valid,
    output logic                     o_ready,
    input  rv_isa_pkg::addr_t        i_pc,
    input  rv_isa_pkg::inst_t        i_inst,
    gpr_if.reader                    gpr_port,
    output logic                     o_valid,
    input  logic                     i_ready,
    output cpu_pipe_pkg::dec_to_ex_t o_data
);
    import rv_isa_pkg::*;
    import cpu_pipe_pkg::*;

    logic [6 : 0] w_opcode;
    logic [2 : 0] w_funct3;
    data_t        w_imm_i;
    data_t        w_imm_s;
    data_t        w_imm_b;
    data_t        w_imm_u;
    data_t        w_imm_j;
    ctrl_t        w_ctrl;
    data_t        w_imm;

    function automatic alu_op_e alu_dec(input logic [2 : 0] f3, input logic alt);
        case (f3)
            F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR:  return ALU_XOR;
            F3_SR:   return alt ? ALU_SRA : ALU_SRL;
            F3_OR:   return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic br_type_e br_dec(input logic [2 : 0] f3);
        case (f3)
            F3_BEQ:  return BR_EQ;
            F3_BNE:  return BR_NE;
            F3_BLT:  return BR_LT;
            F3_BGE:  return BR_GE;
            F3_BLTU: return BR_LTU;
            F3_BGEU: return BR_GEU;
            default: return BR_NONE;
        endcase
    endfunction

    assign w_opcode = i_inst[6:0];
    assign w_funct3 = i_inst[14:12];

    assign w_imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
    assign w_imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign w_imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                      i_inst[11:8], 1'b0};
    assign w_imm_u = {i_inst[31:12], 12'b0};
    assign w_imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                      i_inst[30:21], 1'b0};

    always_comb begin
        w_ctrl = '0;
        w_imm  = w_imm_i;
        case (w_opcode)
            OP_LUI: begin
                w_ctrl.reg_we   = 1'b1;
                w_ctrl.op_b_sel = OPB_IMM;
                w_imm           = w_imm_u;
            end
            OP_AUIPC: begin
                w_ctrl.reg_we   = 1'b1;
                w_ctrl.op_a_sel = OPA_PC;
                w_ctrl.op_b_sel = OPB_IMM;
                w_imm           = w_imm_u;
            end
            OP_JAL: begin
                w_ctrl.reg_we  = 1'b1;
                w_ctrl.wb_src  = WB_PC4;
                w_ctrl.br_type = BR_JAL;
                w_imm          = w_imm_j;
            end
            OP_JALR: begin
                w_ctrl.reg_we  = 1'b1;
                w_ctrl.wb_src  = WB_PC4;
                w_ctrl.br_type = BR_JALR;
            end
            OP_BRANCH: begin
                w_ctrl.br_type = br_dec(w_funct3);
                w_imm          = w_imm_b;
            end
            OP_LOAD: begin
                w_ctrl.reg_we   = 1'b1;
                w_ctrl.mem_rd   = 1'b1;
                w_ctrl.wb_src   = WB_MEM;
                w_ctrl.op_b_sel = OPB_IMM;
            end
            OP_STORE: begin
                w_ctrl.mem_wr   = 1'b1;
                w_ctrl.op_b_sel = OPB_IMM;
                w_imm           = w_imm_s;
            end
            OP_IMM: begin
                w_ctrl.reg_we   = 1'b1;
                w_ctrl.op_b_sel = OPB_IMM;
                // Bit 30 only selects SRAI since ADDI has no subtract form
                w_ctrl.alu_op   = alu_dec(w_funct3, (w_funct3 == F3_SR) && i_inst[30]);
            end
            OP_REG: begin
                w_ctrl.reg_we = 1'b1;
                w_ctrl.alu_op = alu_dec(w_funct3, i_inst[30]);
            end
            OP_SYSTEM: w_ctrl.ebreak = i_inst[20];
            default: ;
        endcase
    end

    // LUI reuses the adder with x0 as first operand
    assign gpr_port.rs1_id = (w_opcode == OP_LUI) ? '0 : i_inst[19:15];
    assign gpr_port.rs2_id = i_inst[24:20];

    assign o_data.pc      = i_pc;
    assign o_data.ctrl    = w_ctrl;
    assign o_data.rs1_val = gpr_port.rs1_data;
    assign o_data.rs2_val = gpr_port.rs2_data;
    assign o_data.imm     = w_imm;
    assign o_data.rd      = i_inst[11:7];

    assign o_valid = i_valid;
    assign o_ready = i_ready;

endmodule

`default_nettype wire

// File: source/ifu.sv
`timescale 1ns/100ps
`default_nettype none

module ifu (
    input  logic              i_sys_clk,
    input  logic              i_reset,
    input  logic              i_retire,
    input  rv_isa_pkg::addr_t i_next_pc,
    input  logic              i_halt,
    output logic              o_valid,
    input  logic              i_ready,
    output rv_isa_pkg::addr_t o_pc
);
    import rv_isa_pkg::*;

    addr_t r_pc;
    logic  r_pending;
    logic  r_boot;
    logic  w_advance;

    assign w_advance = i_retire && !i_halt;
    assign o_valid   = r_pending;
    assign o_pc      = r_pc;

    always_ff @(posedge i_sys_clk) begin
        if (i_reset) begin
            r_pc      <= RESET_PC;
            r_pending <= 1'b0;
            r_boot    <= 1'b1;
        end else begin
            r_boot <= 1'b0;
            // First fetch follows reset and the rest follow retire
            if (r_boot || w_advance) begin
                r_pending <= 1'b1;
            end else if (r_pending && i_ready) begin
                r_pending <= 1'b0;
            end
            if (w_advance) begin
                r_pc <= i_next_pc;
            end
        end
    end

    a_pc_aligned: assert property (@(posedge i_sys_clk) disable iff (i_reset)
        r_pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: source/lsu.sv
`timescale 1ns/100ps
`default_nettype none

module lsu (
    input  logic                     i_sys_clk,
    input  logic                     i_reset,
    input  logic                     i_valid,
    output logic                     o_ready,
    input  cpu_pipe_pkg::ex_to_mem_t i_data,
    output rv_isa_pkg::addr_t        o_ram_addr,
    input  rv_isa_pkg::data_t        i_ram_data,
    output logic                     o_ram_we,
    output rv_isa_pkg::data_t        o_ram_wdata,
    gpr_if.writer                    gpr_port,
    output logic                     o_retire,
    output rv_isa_pkg::addr_t        o_next_pc,
    output logic                     o_end_flag
);
    import rv_isa_pkg::*;
    import cpu_pipe_pkg::*;

    logic  r_end;
    data_t w_wb_data;

    // Retires in a single cycle
    assign o_ready = 1'b1;

    assign o_ram_addr  = i_data.alu_res;
    assign o_ram_we    = i_valid && i_data.ctrl.mem_wr;
    assign o_ram_wdata = i_data.store_data;

    always_comb begin
        case (i_data.ctrl.wb_src)
            WB_MEM:  w_wb_data = i_ram_data;
            WB_PC4:  w_wb_data = i_data.pc4;
            default: w_wb_data = i_data.alu_res;
        endcase
    end

    assign gpr_port.wr_en   = i_valid && i_data.ctrl.reg_we;
    assign gpr_port.wr_id   = i_data.rd;
    assign gpr_port.wr_data = w_wb_data;

    assign o_retire  = i_valid;
    assign o_next_pc = i_data.next_pc;

    always_ff @(posedge i_sys_clk) begin
        if (i_reset) begin
            r_end <= 1'b0;
        end else if (i_valid && i_data.ctrl.ebreak) begin
            r_end <= 1'b1;
        end
    end

    // Already high in the EBREAK retire cycle so fetch does not restart
    assign o_end_flag = r_end || (i_valid && i_data.ctrl.ebreak);

    a_mem_aligned: assert property (@(posedge i_sys_clk) disable iff (i_reset)
        i_valid && (i_data.ctrl.mem_rd || i_data.ctrl.mem_wr) |-> o_ram_addr[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: source/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN - 1 : 0] data_t;
    typedef logic [XLEN - 1 : 0] addr_t;
    typedef logic [31 : 0]       inst_t;
    typedef logic [4 : 0]        reg_id_t;

    localparam addr_t   RESET_PC = '0;
    localparam reg_id_t END_REG  = 5'd10;

    // Major opcodes
    localparam logic [6 : 0] OP_LUI    = 7'b0110111;
    localparam logic [6 : 0] OP_AUIPC  = 7'b0010111;
    localparam logic [6 : 0] OP_JAL    = 7'b1101111;
    localparam logic [6 : 0] OP_JALR   = 7'b1100111;
    localparam logic [6 : 0] OP_BRANCH = 7'b1100011;
    localparam logic [6 : 0] OP_LOAD   = 7'b0000011;
    localparam logic [6 : 0] OP_STORE  = 7'b0100011;
    localparam logic [6 : 0] OP_IMM    = 7'b0010011;
    localparam logic [6 : 0] OP_REG    = 7'b0110011;
    localparam logic [6 : 0] OP_SYSTEM = 7'b1110011;

    // Branch conditions
    localparam logic [2 : 0] F3_BEQ  = 3'b000;
    localparam logic [2 : 0] F3_BNE  = 3'b001;
    localparam logic [2 : 0] F3_BLT  = 3'b100;
    localparam logic [2 : 0] F3_BGE  = 3'b101;
    localparam logic [2 : 0] F3_BLTU = 3'b110;
    localparam logic [2 : 0] F3_BGEU = 3'b111;

    // SUB and SRA share ALU function codes with ADD and SRL
    localparam logic [2 : 0] F3_ADD  = 3'b000;
    localparam logic [2 : 0] F3_SLL  = 3'b001;
    localparam logic [2 : 0] F3_SLT  = 3'b010;
    localparam logic [2 : 0] F3_SLTU = 3'b011;
    localparam logic [2 : 0] F3_XOR  = 3'b100;
    localparam logic [2 : 0] F3_SR   = 3'b101;
    localparam logic [2 : 0] F3_OR   = 3'b110;
    localparam logic [2 : 0] F3_AND  = 3'b111;

endpackage

`default_nettype wire

// File: source/stage_reg.sv
`timescale 1ns/100ps
`default_nettype none

module stage_reg #(
    parameter type T = logic
) (
    input  logic i_sys_clk,
    input  logic i_reset,
    input  logic i_valid,
    output logic o_ready,
    input  T     i_data,
    output logic o_valid,
    input  logic i_ready,
    output T     o_data
);

    logic r_valid;
    T     r_data;

    // Accept when empty or when the held item leaves this cycle
    assign o_ready = !r_valid || i_ready;
    assign o_valid = r_valid;
    assign o_data  = r_data;

    always_ff @(posedge i_sys_clk) begin
        if (i_reset) begin
            r_valid <= 1'b0;
        end else if (o_ready) begin
            r_valid <= i_valid;
        end
    end

    always_ff @(posedge i_sys_clk) begin
        if (o_ready && i_valid) begin
            r_data <= i_data;
        end
    end

    // Upstream keeps its offer until it is taken
    a_hold_stable: assert property (@(posedge i_sys_clk) disable iff (i_reset)
        i_valid && !o_ready |=> i_valid && $stable(i_data));

endmodule

`default_nettype wire
